// ==== verilog/rnn_pkg.sv ====
package rnn_pkg;

    // Network sizes
    localparam int VOCAB_SIZE = 76;
    localparam int EMBED_SIZE = 4;
    localparam int HIDDEN_SIZE = 8;
    localparam int FRAC_BITS = 8;                    // Q8.8

    // Parameter memory
    localparam int MEM_DEPTH = 416;
    localparam int MEM_ADDR_BITS = 9;

    // Memory layout
    localparam int EMBED_BASE = 0;                   // Token x EMBED_SIZE
    localparam int W_IH_BASE = 304;                  // Neuron x EMBED_SIZE
    localparam int W_HH_BASE = 336;                  // Neuron x HIDDEN_SIZE
    localparam int B_IH_BASE = 400;
    localparam int B_HH_BASE = 408;

    typedef logic signed [15:0] word_t;
    typedef logic [6:0] token_t;
    typedef logic [MEM_ADDR_BITS-1:0] mem_addr_t;

    typedef word_t [EMBED_SIZE-1:0] embed_vec_t;
    typedef word_t [HIDDEN_SIZE-1:0] hidden_vec_t;

    typedef struct packed {
        logic valid;
        mem_addr_t addr;
    } mem_req_t;

    typedef struct packed {
        logic valid;
        word_t data;
    } mem_rsp_t;

    typedef struct packed {
        logic en;
        mem_addr_t addr;
        word_t data;
    } mem_wr_t;

endpackage

// ==== verilog/param_mem.sv ====
module param_mem (
    input logic clk,
    input rnn_pkg::mem_wr_t load,
    input rnn_pkg::mem_req_t req,
    output rnn_pkg::mem_rsp_t rsp
);

    rnn_pkg::word_t mem [rnn_pkg::MEM_DEPTH];

    always_ff @(posedge clk)
    begin
        if (load.en)
        begin
            mem[load.addr] <= load.data;
        end
    end

    // One registered read per cycle
    always_ff @(posedge clk)
    begin
        rsp.valid <= req.valid;
        rsp.data <= mem[req.addr];
    end

    a_read_in_range: assert property (@(posedge clk)
        req.valid |-> req.addr < rnn_pkg::MEM_DEPTH);

endmodule

// ==== verilog/mem_arbiter.sv ====
module mem_arbiter (
    input logic clk,
    input logic reset,
    input rnn_pkg::mem_req_t loader_req,
    input rnn_pkg::mem_req_t engine_req,
    output rnn_pkg::mem_req_t mem_req,
    input rnn_pkg::mem_rsp_t mem_rsp,
    output rnn_pkg::mem_rsp_t loader_rsp,
    output rnn_pkg::mem_rsp_t engine_rsp
);

    logic owner_engine;                              // Owner of the read in flight
    logic engine_live;
    logic loader_live;

    // A requester still holds its request in the cycle its data returns
    assign engine_live = engine_req.valid && !engine_rsp.valid;
    assign loader_live = loader_req.valid && !loader_rsp.valid;

    always_comb
    begin
        mem_req.valid = engine_live || loader_live;
        if (engine_live)
        begin
            mem_req.addr = engine_req.addr;          // Engine has priority
        end
        else
        begin
            mem_req.addr = loader_req.addr;
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            owner_engine <= 1'b0;
        end
        else if (mem_req.valid)
        begin
            owner_engine <= engine_live;
        end
    end

    always_comb
    begin
        engine_rsp.valid = mem_rsp.valid && owner_engine;
        engine_rsp.data = mem_rsp.data;
        loader_rsp.valid = mem_rsp.valid && !owner_engine;
        loader_rsp.data = mem_rsp.data;
    end

    // Each response goes to a requester that still waits for it
    a_owner_waiting: assert property (@(posedge clk) disable iff (reset)
        mem_rsp.valid |-> (owner_engine ? engine_req.valid : loader_req.valid));

endmodule

// ==== verilog/embedding_loader.sv ====
module embedding_loader (
    input logic clk,
    input logic reset,
    input logic execute,
    input rnn_pkg::token_t token,
    output logic token_ready,
    output rnn_pkg::mem_req_t req,
    input rnn_pkg::mem_rsp_t rsp,
    output logic embed_valid,
    output rnn_pkg::embed_vec_t embed,
    input logic embed_release
);

    typedef logic [$clog2(rnn_pkg::EMBED_SIZE):0] fill_t;

    typedef struct packed {
        logic full;                                  // Token accepted
        fill_t fill;                                 // Words fetched so far
        rnn_pkg::token_t token;
        rnn_pkg::embed_vec_t data;
    } slot_t;

    slot_t slots [2];
    logic wr_ptr;
    logic rd_ptr;
    logic fetch_ptr;
    logic fetch_active;
    logic accept;
    logic [$clog2(rnn_pkg::EMBED_SIZE)-1:0] fill_idx;

    assign token_ready = !slots[wr_ptr].full;
    assign accept = execute && token_ready;

    assign embed_valid = slots[rd_ptr].full && slots[rd_ptr].fill == fill_t'(rnn_pkg::EMBED_SIZE);
    assign embed = slots[rd_ptr].data;

    // Oldest slot still waiting for words
    assign fetch_ptr = (slots[rd_ptr].full && slots[rd_ptr].fill != fill_t'(rnn_pkg::EMBED_SIZE))
                       ? rd_ptr : !rd_ptr;
    assign fetch_active = slots[fetch_ptr].full
                          && slots[fetch_ptr].fill != fill_t'(rnn_pkg::EMBED_SIZE);
    assign fill_idx = slots[fetch_ptr].fill[$clog2(rnn_pkg::EMBED_SIZE)-1:0];

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            for (int i = 0; i < 2; i++)
            begin
                slots[i].full <= 1'b0;
                slots[i].fill <= '0;
            end
            wr_ptr <= 1'b0;
            rd_ptr <= 1'b0;
            req.valid <= 1'b0;
        end
        else
        begin
            if (accept)
            begin
                slots[wr_ptr].full <= 1'b1;
                slots[wr_ptr].fill <= '0;
                slots[wr_ptr].token <= token;
                wr_ptr <= !wr_ptr;
            end
            if (embed_release)
            begin
                slots[rd_ptr].full <= 1'b0;
                rd_ptr <= !rd_ptr;
            end
            if (rsp.valid)
            begin
                slots[fetch_ptr].data[fill_idx] <= rsp.data;
                slots[fetch_ptr].fill <= slots[fetch_ptr].fill + 1'b1;
                req.valid <= slots[fetch_ptr].fill != fill_t'(rnn_pkg::EMBED_SIZE - 1);
                req.addr <= req.addr + 1'b1;         // Next word of the row
            end
            else if (!req.valid && fetch_active)
            begin
                req.valid <= 1'b1;
                req.addr <= rnn_pkg::mem_addr_t'(rnn_pkg::EMBED_BASE
                            + slots[fetch_ptr].token * rnn_pkg::EMBED_SIZE);
            end
        end
    end

    a_no_overfill: assert property (@(posedge clk) disable iff (reset)
        rsp.valid |-> fetch_active);

    a_token_range: assert property (@(posedge clk) disable iff (reset)
        accept |-> token < rnn_pkg::VOCAB_SIZE);

endmodule

// ==== verilog/fixed_mac.sv ====
module fixed_mac (
    input logic clk,
    input logic clear,
    input logic mul_en,
    input logic add_en,
    input rnn_pkg::word_t a,
    input rnn_pkg::word_t b,
    output rnn_pkg::word_t acc
);

    logic signed [31:0] product;
    rnn_pkg::word_t product_q;

    assign product = a * b;                          // Full signed product
    assign product_q = rnn_pkg::word_t'(product >>> rnn_pkg::FRAC_BITS);

    // Sums wrap modulo 2^16
    always_ff @(posedge clk)
    begin
        if (clear)
        begin
            acc <= '0;
        end
        else if (mul_en)
        begin
            acc <= acc + product_q;
        end
        else if (add_en)
        begin
            acc <= acc + a;                          // Bias term
        end
    end

endmodule

// ==== verilog/neuron_engine.sv ====
module neuron_engine (
    input logic clk,
    input logic reset,
    input logic embed_valid,
    input rnn_pkg::embed_vec_t embed,
    output logic embed_release,
    output rnn_pkg::mem_req_t req,
    input rnn_pkg::mem_rsp_t rsp,
    output logic hidden_valid,
    output rnn_pkg::hidden_vec_t hidden
);

    typedef enum logic [1:0] {
        IDLE,
        READ,
        STORE,
        FINISH
    } state_t;

    typedef logic [$clog2(rnn_pkg::EMBED_SIZE + rnn_pkg::HIDDEN_SIZE + 2)-1:0] term_t;
    typedef logic [$clog2(rnn_pkg::HIDDEN_SIZE)-1:0] neuron_t;

    state_t state;
    neuron_t neuron;
    term_t term;                                     // Read index within a neuron
    neuron_t hh_idx;
    logic req_valid;
    logic is_bias;
    logic last_term;
    rnn_pkg::mem_addr_t read_addr;
    rnn_pkg::hidden_vec_t prev_hidden;
    rnn_pkg::hidden_vec_t new_hidden;
    rnn_pkg::word_t operand;
    rnn_pkg::word_t acc;

    // Term order is W_IH x4, B_IH, W_HH x8, B_HH
    assign hh_idx = neuron_t'(term - term_t'(rnn_pkg::EMBED_SIZE + 1));
    assign is_bias = term == term_t'(rnn_pkg::EMBED_SIZE)
                     || term == term_t'(rnn_pkg::EMBED_SIZE + rnn_pkg::HIDDEN_SIZE + 1);
    assign last_term = term == term_t'(rnn_pkg::EMBED_SIZE + rnn_pkg::HIDDEN_SIZE + 1);

    always_comb
    begin
        if (term < term_t'(rnn_pkg::EMBED_SIZE))
        begin
            read_addr = rnn_pkg::mem_addr_t'(rnn_pkg::W_IH_BASE
                        + neuron * rnn_pkg::EMBED_SIZE + term);
            operand = embed[term[$clog2(rnn_pkg::EMBED_SIZE)-1:0]];
        end
        else if (term == term_t'(rnn_pkg::EMBED_SIZE))
        begin
            read_addr = rnn_pkg::mem_addr_t'(rnn_pkg::B_IH_BASE + neuron);
            operand = '0;
        end
        else if (!last_term)
        begin
            read_addr = rnn_pkg::mem_addr_t'(rnn_pkg::W_HH_BASE
                        + neuron * rnn_pkg::HIDDEN_SIZE + hh_idx);
            operand = prev_hidden[hh_idx];
        end
        else
        begin
            read_addr = rnn_pkg::mem_addr_t'(rnn_pkg::B_HH_BASE + neuron);
            operand = '0;
        end
    end

    assign req.valid = req_valid;
    assign req.addr = read_addr;
    assign embed_release = state == FINISH;
    assign hidden = prev_hidden;

    fixed_mac u_mac (
        .clk    (clk),
        .clear  (state == IDLE || state == STORE),
        .mul_en (state == READ && rsp.valid && !is_bias),
        .add_en (state == READ && rsp.valid && is_bias),
        .a      (rsp.data),
        .b      (operand),
        .acc    (acc)
    );

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state <= IDLE;
            neuron <= '0;
            term <= '0;
            req_valid <= 1'b0;
            hidden_valid <= 1'b0;
            prev_hidden <= '0;
        end
        else
        begin
            hidden_valid <= 1'b0;
            unique case (state)
                IDLE:
                begin
                    if (embed_valid)
                    begin
                        neuron <= '0;
                        term <= '0;
                        req_valid <= 1'b1;
                        state <= READ;
                    end
                end
                READ:
                begin
                    if (rsp.valid)
                    begin
                        if (last_term)
                        begin
                            req_valid <= 1'b0;
                            state <= STORE;
                        end
                        else
                        begin
                            term <= term + 1'b1;
                        end
                    end
                end
                STORE:
                begin
                    new_hidden[neuron] <= acc;
                    if (neuron == neuron_t'(rnn_pkg::HIDDEN_SIZE - 1))
                    begin
                        state <= FINISH;
                    end
                    else
                    begin
                        neuron <= neuron + 1'b1;
                        term <= '0;
                        req_valid <= 1'b1;
                        state <= READ;
                    end
                end
                FINISH:
                begin
                    prev_hidden <= new_hidden;
                    hidden_valid <= 1'b1;
                    state <= IDLE;
                end
            endcase
        end
    end

    a_rsp_outstanding: assert property (@(posedge clk) disable iff (reset)
        rsp.valid |-> state == READ && req_valid);

    a_embed_held: assert property (@(posedge clk) disable iff (reset)
        state != IDLE |-> embed_valid);

endmodule

// ==== verilog/rnn_top.sv ====
module rnn_top (
    input logic clk,
    input logic reset,
    input logic execute,
    input rnn_pkg::token_t token,
    input rnn_pkg::mem_wr_t load,
    output logic token_ready,
    output logic hidden_valid,
    output rnn_pkg::hidden_vec_t hidden
);

    rnn_pkg::mem_req_t loader_req;
    rnn_pkg::mem_req_t engine_req;
    rnn_pkg::mem_req_t mem_req;
    rnn_pkg::mem_rsp_t mem_rsp;
    rnn_pkg::mem_rsp_t loader_rsp;
    rnn_pkg::mem_rsp_t engine_rsp;
    rnn_pkg::embed_vec_t embed;
    logic embed_valid;
    logic embed_release;

    param_mem u_mem (
        .clk  (clk),
        .load (load),
        .req  (mem_req),
        .rsp  (mem_rsp)
    );

    mem_arbiter u_arb (
        .clk        (clk),
        .reset      (reset),
        .loader_req (loader_req),
        .engine_req (engine_req),
        .mem_req    (mem_req),
        .mem_rsp    (mem_rsp),
        .loader_rsp (loader_rsp),
        .engine_rsp (engine_rsp)
    );

    embedding_loader u_loader (
        .clk           (clk),
        .reset         (reset),
        .execute       (execute),
        .token         (token),
        .token_ready   (token_ready),
        .req           (loader_req),
        .rsp           (loader_rsp),
        .embed_valid   (embed_valid),
        .embed         (embed),
        .embed_release (embed_release)
    );

    neuron_engine u_engine (
        .clk           (clk),
        .reset         (reset),
        .embed_valid   (embed_valid),
        .embed         (embed),
        .embed_release (embed_release),
        .req           (engine_req),
        .rsp           (engine_rsp),
        .hidden_valid  (hidden_valid),
        .hidden        (hidden)
    );

endmodule

// ==== bench/rnn_ref.svh ====
`ifndef RNN_REF_SVH
`define RNN_REF_SVH

rnn_pkg::word_t param_img [rnn_pkg::MEM_DEPTH];     // Words written through the load port

function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
endfunction

// Wide Q8.8 product that the caller truncates with the final sum
function automatic longint q88_mul(input rnn_pkg::word_t a, input rnn_pkg::word_t b);
    longint p;
    p = longint'(a) * longint'(b);
    return p >>> rnn_pkg::FRAC_BITS;
endfunction

function automatic rnn_pkg::hidden_vec_t rnn_step(input rnn_pkg::token_t tok,
                                                  input rnn_pkg::hidden_vec_t prev);
    rnn_pkg::hidden_vec_t result;
    int row;
    longint sum;
    row = rnn_pkg::EMBED_BASE + int'(tok) * rnn_pkg::EMBED_SIZE;
    for (int n = 0; n < rnn_pkg::HIDDEN_SIZE; n++)
    begin
        sum = longint'(param_img[rnn_pkg::B_IH_BASE + n])
              + longint'(param_img[rnn_pkg::B_HH_BASE + n]);
        for (int e = 0; e < rnn_pkg::EMBED_SIZE; e++)
            sum += q88_mul(param_img[rnn_pkg::W_IH_BASE + n * rnn_pkg::EMBED_SIZE + e],
                           param_img[row + e]);
        for (int h = 0; h < rnn_pkg::HIDDEN_SIZE; h++)
            sum += q88_mul(param_img[rnn_pkg::W_HH_BASE + n * rnn_pkg::HIDDEN_SIZE + h],
                           prev[h]);
        result[n] = rnn_pkg::word_t'(sum);         // Low 16 bits wrap like the cell
    end
    return result;
endfunction

`endif

// ==== bench/rnn_tb.sv ====
module rnn_tb;

    `include "rnn_ref.svh"

    localparam int TOKEN_TOTAL = 40;                 // Tokens sent over all tests
    localparam int WATCHDOG_CYCLES = (TOKEN_TOTAL + 4) * 2000;
    localparam int RESULT_TIMEOUT = 1000;            // Several times the compute time of one token

    logic clk;
    logic reset;
    logic execute;
    rnn_pkg::token_t token;
    rnn_pkg::mem_wr_t load;
    logic token_ready;
    logic hidden_valid;
    rnn_pkg::hidden_vec_t hidden;

    logic [31:0] rng_state = 32'hb41e;
    rnn_pkg::hidden_vec_t ref_prev;                  // Expected state after the last accepted token
    rnn_pkg::hidden_vec_t exp_q [$];
    int accepted_count = 0;
    int result_count = 0;
    int error_count = 0;

    rnn_top i_dut (.*);

    initial
    begin
        clk = 1'b0;
        forever #4 clk = !clk;
    end

    initial
    begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout: the tests did not end within %0d cycles", WATCHDOG_CYCLES);
        $display("Finished with errors");
        $finish;
    end

    task automatic check_hidden(input rnn_pkg::hidden_vec_t got, input rnn_pkg::hidden_vec_t exp);
        if (got !== exp)
        begin
            error_count++;
            for (int n = 0; n < rnn_pkg::HIDDEN_SIZE; n++)
                if (got[n] !== exp[n])
                    $display("FAIL %0t: hidden[%0d] is %h, expected %h", $time, n, got[n], exp[n]);
        end
    endtask

    task automatic check_count(input int got, input int exp, input string what);
        if (got != exp)
        begin
            error_count++;
            $display("FAIL %0t: %s gave %0d results for %0d tokens", $time, what, got, exp);
        end
    endtask

    task automatic check_ready(input logic got, input logic exp, input string what);
        if (got !== exp)
        begin
            error_count++;
            $display("FAIL %0t: token_ready is %b %s, expected %b", $time, got, what, exp);
        end
    endtask

    // Results come out in token order
    always @(negedge clk)
    begin
        if (!reset && hidden_valid)
        begin
            if (exp_q.size() == 0)
            begin
                error_count++;
                $display("Result at time %0t arrived with no token pending", $time);
            end
            else
                check_hidden(hidden, exp_q.pop_front());
            result_count++;
        end
    end

    function automatic rnn_pkg::token_t random_token();
        rng_state = xorshift32(rng_state);
        return rnn_pkg::token_t'(rng_state % rnn_pkg::VOCAB_SIZE);
    endfunction

    task automatic wait_drive_time();
        @(posedge clk);
        #1;
    endtask

    task automatic note_accept(input rnn_pkg::token_t t);
        ref_prev = rnn_step(t, ref_prev);
        exp_q.push_back(ref_prev);
        accepted_count++;
    endtask

    task automatic pulse_reset(input int cycles);
        reset = 1'b1;
        exp_q.delete();                              // Unfinished tokens are lost
        accepted_count = result_count;
        ref_prev = '0;
        repeat (cycles) wait_drive_time();
        reset = 1'b0;
        check_ready(token_ready, 1'b1, "after reset");
    endtask

    task automatic load_params(input logic extreme);
        for (int i = 0; i < rnn_pkg::MEM_DEPTH; i++)
        begin
            rng_state = xorshift32(rng_state);
            if (extreme)
                param_img[i] = (^rnn_pkg::mem_addr_t'(i)) ? 16'sh7fff : 16'sh8000;
            else
                param_img[i] = {{4{rng_state[11]}}, rng_state[11:0]};
            wait_drive_time();
            load.en = 1'b1;
            load.addr = rnn_pkg::mem_addr_t'(i);
            load.data = param_img[i];
        end
        wait_drive_time();
        load.en = 1'b0;
    endtask

    task automatic send_token(input rnn_pkg::token_t t);
        do
        begin
            wait_drive_time();
            execute = 1'b1;
            token = t;
            @(negedge clk);
        end
        while (!token_ready);
        note_accept(t);
        wait_drive_time();
        execute = 1'b0;
    endtask

    // Execute stays high with a new token every cycle whether accepted or not
    task automatic stream_tokens(input int n);
        int sent;
        sent = 0;
        while (sent < n)
        begin
            wait_drive_time();
            execute = 1'b1;
            token = random_token();
            @(negedge clk);
            if (token_ready)
            begin
                note_accept(token);
                sent++;
            end
        end
        wait_drive_time();
        execute = 1'b0;
    endtask

    // Gives up when no result arrives for RESULT_TIMEOUT cycles
    task automatic wait_results(input int target);
        int idle_cycles;
        int seen;
        idle_cycles = 0;
        while (result_count < target && idle_cycles < RESULT_TIMEOUT)
        begin
            seen = result_count;
            @(posedge clk);
            if (result_count == seen)
                idle_cycles++;
            else
                idle_cycles = 0;
        end
        if (result_count < target)
        begin
            error_count++;
            $display("No result for %0d cycles, %0d of %0d results arrived", RESULT_TIMEOUT,
                     result_count, target);
        end
    endtask

    initial
    begin
        reset = 1'b1;
        execute = 1'b0;
        token = '0;
        load = '0;
        ref_prev = '0;
        pulse_reset(10);
        load_params(1'b0);

        send_token(rnn_pkg::token_t'(17));           // From zero state
        wait_results(accepted_count);
        check_count(result_count, accepted_count, "single token");

        repeat (20)
        begin
            send_token(random_token());
            wait_results(accepted_count);
        end
        check_count(result_count, accepted_count, "token sequence");

        stream_tokens(12);
        wait_results(accepted_count);
        check_count(result_count, accepted_count, "back-to-back tokens");

        stream_tokens(3);
        wait_results(accepted_count - 2);            // Reset while two tokens are pending
        wait_drive_time();
        pulse_reset(4);
        send_token(random_token());
        wait_results(accepted_count);
        check_count(result_count, accepted_count, "reset mid-sequence");

        load_params(1'b1);
        repeat (3)
        begin
            send_token(random_token());
            wait_results(accepted_count);
        end
        check_count(result_count, accepted_count, "extreme parameters");

        $display("Tokens %0d, results %0d, errors %0d", accepted_count, result_count,
                 error_count);
        if (error_count == 0)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    end

endmodule

// ==== files.f ====
+incdir+bench
verilog/rnn_pkg.sv
verilog/param_mem.sv
verilog/mem_arbiter.sv
verilog/embedding_loader.sv
verilog/fixed_mac.sv
verilog/neuron_engine.sv
verilog/rnn_top.sv
bench/rnn_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the RNN cell testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal -f files.f --top-module rnn_tb -o rnn_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/rnn_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^Finished with no errors$" sim.log; then
    exit 0
fi
echo "Pass message not found in sim.log"
exit 1
